//--- design/decode_pkg.sv
//**************************************************************************
// Decode stage package
// Field widths, instruction field types, opcode encodings, ALU operation
// codes and interrupt vector size shared by the decode stage blocks
//**************************************************************************

package decode_pkg;

    // Interrupt vector
    localparam int INT_LINES    = 24;
    localparam int INVALID_LINE = 0;            // Undefined opcode and INT 0

    // Instruction fields
    typedef logic [31:0] inst_t;                // Full instruction word
    typedef logic [7:0]  opcode_t;              // Bits 31..24
    typedef logic [3:0]  reg_idx_t;             // Rd 23..20, Rm 19..16, Rn 15..12
    typedef logic [15:0] imm_t;                 // Bits 15..0
    typedef logic [4:0]  shamt_t;               // Bits 11..7
    typedef logic [1:0]  shdir_t;               // Bits 6..5

    typedef logic [INT_LINES-1:0] int_vec_t;

    // Operation requested from the execute stage ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_MOV = 4'd5
    } alu_op_e;

    // Memory access
    localparam opcode_t OP_LDRI = 8'h14;        // Rd <- [Rm + imm]
    localparam opcode_t OP_LDRA = 8'h15;        // Rd <- [Rm + sh(Rn)]
    localparam opcode_t OP_STRI = 8'h34;        // [Rm + imm] <- Rd
    localparam opcode_t OP_STRA = 8'h35;        // [Rm + sh(Rn)] <- Rd

    // Moves
    localparam opcode_t OP_MOVI = 8'h24;        // Rd <- imm
    localparam opcode_t OP_MOVN = 8'h25;        // Rd <- sh(Rn)

    // Register arithmetic and logic
    localparam opcode_t OP_ADD  = 8'h40;
    localparam opcode_t OP_SUB  = 8'h48;
    localparam opcode_t OP_RSUB = 8'h4C;        // Rd <- sh(Rn) - Rm
    localparam opcode_t OP_AND  = 8'h50;
    localparam opcode_t OP_OR   = 8'h58;
    localparam opcode_t OP_XOR  = 8'h5C;

    // Immediate arithmetic and logic
    localparam opcode_t OP_ADDI = 8'h41;
    localparam opcode_t OP_SUBI = 8'h49;
    localparam opcode_t OP_ANDI = 8'h51;
    localparam opcode_t OP_ORI  = 8'h59;
    localparam opcode_t OP_XORI = 8'h5D;

    // Compares only update flags
    localparam opcode_t OP_CMP  = 8'h68;        // Rm - sh(Rn)
    localparam opcode_t OP_CMPI = 8'h69;        // Rm - imm

    // Software interrupt, number in imm
    localparam opcode_t OP_INT  = 8'hF0;

endpackage

//--- design/decode_flow.sv
//**************************************************************************
// Decode flow control
// One-entry holding stage between fetch and execute. Tracks whether a
// decoded instruction waits for execute and drives both ready levels
//**************************************************************************

`timescale 1ns/1ps

module decode_flow (
    input  logic clk,
    input  logic reset,
    input  logic inst_req,                      // Fetch offers a word
    input  logic exec_rdy,                      // Execute can take the entry
    input  logic halted,                        // Trap seen, stage frozen
    input  logic trap_accept,                   // Accepted word is a trap
    output logic inst_rdy,
    output logic accept,
    output logic exec_req,
    output logic empty
);

    logic full;                                 // Entry holds a valid instruction

    // Ready when the entry is free or drains in this same cycle
    assign inst_rdy = !halted && (!full || exec_rdy);
    assign accept   = inst_req && inst_rdy;
    assign exec_req = full;
    assign empty    = !full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (accept && !trap_accept) begin
            full <= 1'b1;                       // New entry replaces a leaving one
        end else if (exec_rdy) begin
            full <= 1'b0;                       // Execute took it
        end
    end

    // A trap leaves nothing for execute and freezes the fetch side
    assert property (@(posedge clk) disable iff (reset)
        trap_accept |=> (halted && !inst_rdy && !exec_req));

endmodule

//--- design/inst_decoder.sv
//**************************************************************************
// Instruction decoder
// Splits the instruction word into fields, maps the opcode to execute
// control levels and registers them when the word is accepted. Flags
// undefined opcodes and software interrupts for the trap controller
//**************************************************************************

`timescale 1ns/1ps

module inst_decoder (
    input  logic                clk,
    input  logic                reset,
    input  decode_pkg::inst_t   inst,
    input  logic                accept,
    output decode_pkg::alu_op_e alu_op,
    output logic                src_imm,        // Operand B is imm
    output logic                reverse,        // Swap ALU operands
    output logic                mem_read,
    output logic                mem_write,
    output logic                write_back,
    output decode_pkg::shamt_t  shamt,
    output decode_pkg::shdir_t  shdir,
    output decode_pkg::imm_t    imm,
    output decode_pkg::reg_idx_t rd,
    output decode_pkg::reg_idx_t rm,
    output decode_pkg::reg_idx_t rn,
    output logic                trap_invalid,   // Offered word has no table entry
    output logic                trap_int        // Offered word is INT
);

    decode_pkg::opcode_t   opcode;
    decode_pkg::alu_op_e   alu_op_n;
    logic                  src_imm_n;
    logic                  reverse_n;
    logic                  mem_read_n;
    logic                  mem_write_n;
    logic                  write_back_n;
    logic                  imm_form;            // Immediate operand layout
    decode_pkg::shamt_t    shamt_n;
    decode_pkg::imm_t      imm_n;

    assign opcode = inst[31:24];

    // Opcode table
    always_comb begin
        alu_op_n     = decode_pkg::ALU_ADD;
        reverse_n    = 1'b0;
        mem_read_n   = 1'b0;
        mem_write_n  = 1'b0;
        write_back_n = 1'b0;
        imm_form     = 1'b0;
        trap_invalid = 1'b0;
        trap_int     = 1'b0;

        case (opcode)
            decode_pkg::OP_LDRI: begin
                mem_read_n   = 1'b1;
                write_back_n = 1'b1;
                imm_form     = 1'b1;
            end
            decode_pkg::OP_LDRA: begin
                mem_read_n   = 1'b1;
                write_back_n = 1'b1;
            end
            decode_pkg::OP_STRI: begin
                mem_write_n  = 1'b1;
                imm_form     = 1'b1;
            end
            decode_pkg::OP_STRA: begin
                mem_write_n  = 1'b1;
            end
            decode_pkg::OP_MOVI: begin
                alu_op_n     = decode_pkg::ALU_MOV;
                write_back_n = 1'b1;
                imm_form     = 1'b1;
            end
            decode_pkg::OP_MOVN: begin
                alu_op_n     = decode_pkg::ALU_MOV;
                write_back_n = 1'b1;
            end
            decode_pkg::OP_ADD,
            decode_pkg::OP_ADDI: begin
                write_back_n = 1'b1;
                imm_form     = (opcode == decode_pkg::OP_ADDI);
            end
            decode_pkg::OP_SUB,
            decode_pkg::OP_SUBI: begin
                alu_op_n     = decode_pkg::ALU_SUB;
                write_back_n = 1'b1;
                imm_form     = (opcode == decode_pkg::OP_SUBI);
            end
            decode_pkg::OP_RSUB: begin
                alu_op_n     = decode_pkg::ALU_SUB;
                reverse_n    = 1'b1;            // sh(Rn) - Rm
                write_back_n = 1'b1;
            end
            decode_pkg::OP_AND,
            decode_pkg::OP_ANDI: begin
                alu_op_n     = decode_pkg::ALU_AND;
                write_back_n = 1'b1;
                imm_form     = (opcode == decode_pkg::OP_ANDI);
            end
            decode_pkg::OP_OR,
            decode_pkg::OP_ORI: begin
                alu_op_n     = decode_pkg::ALU_OR;
                write_back_n = 1'b1;
                imm_form     = (opcode == decode_pkg::OP_ORI);
            end
            decode_pkg::OP_XOR,
            decode_pkg::OP_XORI: begin
                alu_op_n     = decode_pkg::ALU_XOR;
                write_back_n = 1'b1;
                imm_form     = (opcode == decode_pkg::OP_XORI);
            end
            decode_pkg::OP_CMP,
            decode_pkg::OP_CMPI: begin
                alu_op_n     = decode_pkg::ALU_SUB;     // Flags only
                imm_form     = (opcode == decode_pkg::OP_CMPI);
            end
            decode_pkg::OP_INT: begin
                trap_int     = 1'b1;
                imm_form     = 1'b1;            // imm carries the number
            end
            default: begin
                trap_invalid = 1'b1;
            end
        endcase
    end

    // Immediate forms take imm, register forms take the shift amount
    assign src_imm_n = imm_form && !trap_int;
    assign imm_n     = imm_form ? inst[15:0] : '0;
    assign shamt_n   = imm_form ? '0 : inst[11:7];

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op     <= decode_pkg::ALU_ADD;
            src_imm    <= 1'b0;
            reverse    <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            write_back <= 1'b0;
        end else if (accept) begin
            alu_op     <= alu_op_n;
            src_imm    <= src_imm_n;
            reverse    <= reverse_n;
            mem_read   <= mem_read_n;
            mem_write  <= mem_write_n;
            write_back <= write_back_n;
        end
    end

    // Operand fields
    always_ff @(posedge clk) begin
        if (accept) begin
            shamt <= shamt_n;
            shdir <= inst[6:5];                 // Passed through for every form
            imm   <= imm_n;
            rd    <= inst[23:20];
            rm    <= inst[19:16];
            rn    <= inst[15:12];
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

endmodule

//--- design/trap_ctrl.sv
//**************************************************************************
// Trap controller
// Halts the stage on an undefined opcode or INT and, once the pipeline
// has drained, raises the matching interrupt line for one cycle
//**************************************************************************

`timescale 1ns/1ps

module trap_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 accept,
    input  logic                 trap_invalid,
    input  logic                 trap_int,
    input  decode_pkg::imm_t     int_num,       // Registered INT number
    input  logic                 empty,
    input  logic                 exec_rdy,
    output logic                 halted,
    output logic                 trap_accept,
    output decode_pkg::int_vec_t int_line
);

    logic                 pending;              // Trap waits for the drain
    logic                 was_invalid;          // Kind of the recorded trap
    logic                 fire;
    decode_pkg::int_vec_t line_sel;

    assign trap_accept = accept && (trap_invalid || trap_int);
    assign fire        = pending && empty && exec_rdy;

    // Map the trap to one line, INT numbers past the vector raise nothing
    always_comb begin
        line_sel = '0;
        if (was_invalid || int_num == '0) begin
            line_sel[decode_pkg::INVALID_LINE] = 1'b1;
        end else if (int_num < decode_pkg::INT_LINES) begin
            line_sel[int_num[4:0]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halted      <= 1'b0;
            pending     <= 1'b0;
            was_invalid <= 1'b0;
            int_line    <= '0;
        end else begin
            int_line <= '0;                     // One cycle pulse
            if (trap_accept) begin
                halted      <= 1'b1;            // Held until reset
                pending     <= 1'b1;
                was_invalid <= trap_invalid;
            end else if (fire) begin
                pending  <= 1'b0;
                int_line <= line_sel;
            end
        end
    end

    // Single line, single cycle, and only from a halted stage
    assert property (@(posedge clk) disable iff (reset)
        (|int_line) |-> (halted && $onehot0(int_line)) ##1 (int_line == '0));

endmodule

//--- design/decode_stage.sv
//**************************************************************************
// Decode stage top
// Connects the flow control, the instruction decoder and the trap
// controller between fetch, execute and the interrupt vector
//**************************************************************************

`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  decode_pkg::inst_t    inst,
    input  logic                 inst_req,
    output logic                 inst_rdy,
    output logic                 exec_req,
    input  logic                 exec_rdy,
    output decode_pkg::alu_op_e  alu_op,
    output logic                 src_imm,
    output logic                 reverse,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 write_back,
    output decode_pkg::shamt_t   shamt,
    output decode_pkg::shdir_t   shdir,
    output decode_pkg::imm_t     imm,
    output decode_pkg::reg_idx_t rd,
    output decode_pkg::reg_idx_t rm,
    output decode_pkg::reg_idx_t rn,
    output decode_pkg::int_vec_t int_line
);

    logic accept;
    logic empty;
    logic halted;
    logic trap_accept;
    logic trap_invalid;
    logic trap_int;

    decode_flow u_flow (
        .clk         (clk),
        .reset       (reset),
        .inst_req    (inst_req),
        .exec_rdy    (exec_rdy),
        .halted      (halted),
        .trap_accept (trap_accept),
        .inst_rdy    (inst_rdy),
        .accept      (accept),
        .exec_req    (exec_req),
        .empty       (empty)
    );

    inst_decoder u_decoder (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .accept       (accept),
        .alu_op       (alu_op),
        .src_imm      (src_imm),
        .reverse      (reverse),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .write_back   (write_back),
        .shamt        (shamt),
        .shdir        (shdir),
        .imm          (imm),
        .rd           (rd),
        .rm           (rm),
        .rn           (rn),
        .trap_invalid (trap_invalid),
        .trap_int     (trap_int)
    );

    trap_ctrl u_trap (
        .clk          (clk),
        .reset        (reset),
        .accept       (accept),
        .trap_invalid (trap_invalid),
        .trap_int     (trap_int),
        .int_num      (imm),                    // INT number held by the decoder
        .empty        (empty),
        .exec_rdy     (exec_rdy),
        .halted       (halted),
        .trap_accept  (trap_accept),
        .int_line     (int_line)
    );

endmodule

//--- tb/decode_vectors.svh
//**************************************************************************
// Decode stage test vectors
// Opcodes in the order they are offered, with the expected ALU operation,
// control flags and, for traps, the expected interrupt line
//**************************************************************************

typedef struct packed {
    decode_pkg::opcode_t opcode;
    logic                trap;
    decode_pkg::alu_op_e alu_op;
    logic [4:0]          flags;                 // src_imm, reverse, mem_read, mem_write, write_back
    decode_pkg::imm_t    int_num;
    int                  line;                  // -1 when no line may pulse
} vec_t;

vec_t vecs[$];

task automatic add_vec(
    input decode_pkg::opcode_t op,
    input logic                trap,
    input decode_pkg::alu_op_e alu,
    input logic [4:0]          flags,
    input decode_pkg::imm_t    num,
    input int                  line
);
    vec_t v;
    v.opcode  = op;
    v.trap    = trap;
    v.alu_op  = alu;
    v.flags   = flags;
    v.int_num = num;
    v.line    = line;
    vecs.push_back(v);
endtask

task automatic fill_table();
    // opcode, trap, ALU operation, flags, INT number, interrupt line
    add_vec(decode_pkg::OP_LDRI, 1'b0, decode_pkg::ALU_ADD, 5'b10101, 16'd0, -1);
    add_vec(decode_pkg::OP_LDRA, 1'b0, decode_pkg::ALU_ADD, 5'b00101, 16'd0, -1);
    add_vec(decode_pkg::OP_STRI, 1'b0, decode_pkg::ALU_ADD, 5'b10010, 16'd0, -1);
    add_vec(decode_pkg::OP_STRA, 1'b0, decode_pkg::ALU_ADD, 5'b00010, 16'd0, -1);
    add_vec(decode_pkg::OP_MOVI, 1'b0, decode_pkg::ALU_MOV, 5'b10001, 16'd0, -1);
    add_vec(decode_pkg::OP_MOVN, 1'b0, decode_pkg::ALU_MOV, 5'b00001, 16'd0, -1);
    add_vec(decode_pkg::OP_ADD,  1'b0, decode_pkg::ALU_ADD, 5'b00001, 16'd0, -1);
    add_vec(decode_pkg::OP_SUB,  1'b0, decode_pkg::ALU_SUB, 5'b00001, 16'd0, -1);
    add_vec(decode_pkg::OP_RSUB, 1'b0, decode_pkg::ALU_SUB, 5'b01001, 16'd0, -1);
    add_vec(decode_pkg::OP_INT,  1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd5, 5);
    add_vec(decode_pkg::OP_AND,  1'b0, decode_pkg::ALU_AND, 5'b00001, 16'd0, -1);
    add_vec(decode_pkg::OP_OR,   1'b0, decode_pkg::ALU_OR,  5'b00001, 16'd0, -1);
    add_vec(decode_pkg::OP_XOR,  1'b0, decode_pkg::ALU_XOR, 5'b00001, 16'd0, -1);
    add_vec(decode_pkg::OP_ADDI, 1'b0, decode_pkg::ALU_ADD, 5'b10001, 16'd0, -1);
    add_vec(decode_pkg::OP_SUBI, 1'b0, decode_pkg::ALU_SUB, 5'b10001, 16'd0, -1);
    add_vec(decode_pkg::OP_ANDI, 1'b0, decode_pkg::ALU_AND, 5'b10001, 16'd0, -1);
    add_vec(decode_pkg::OP_ORI,  1'b0, decode_pkg::ALU_OR,  5'b10001, 16'd0, -1);
    add_vec(decode_pkg::OP_XORI, 1'b0, decode_pkg::ALU_XOR, 5'b10001, 16'd0, -1);
    add_vec(decode_pkg::OP_CMP,  1'b0, decode_pkg::ALU_SUB, 5'b00000, 16'd0, -1);
    add_vec(decode_pkg::OP_CMPI, 1'b0, decode_pkg::ALU_SUB, 5'b10000, 16'd0, -1);
    // Traps, each followed by a reset
    add_vec(decode_pkg::OP_INT,  1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd1, 1);
    add_vec(decode_pkg::OP_INT,  1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd23, 23);
    add_vec(decode_pkg::OP_INT,  1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd0, 0);
    add_vec(decode_pkg::OP_INT,  1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd30, -1);
    add_vec(8'hA7,               1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd0, 0);
    add_vec(decode_pkg::OP_ADD,  1'b0, decode_pkg::ALU_ADD, 5'b00001, 16'd0, -1);
    add_vec(8'h00,               1'b1, decode_pkg::ALU_ADD, 5'b00000, 16'd0, 0);
endtask

//--- tb/decode_tb.sv
//**************************************************************************
// Decode stage testbench
// Offers table opcodes with random fields under random execute stalls,
// checks the decoded fields, the hold behavior and the trap interrupts
//**************************************************************************

`timescale 1ns/1ps

module decode_tb;

    typedef logic [43:0] ctrl_t;                // All execute side fields in one word

    logic                 clk      = 1'b0;
    logic                 reset;
    decode_pkg::inst_t    inst;
    logic                 inst_req;
    logic                 inst_rdy;
    logic                 exec_req;
    logic                 exec_rdy = 1'b0;
    decode_pkg::alu_op_e  alu_op;
    logic                 src_imm;
    logic                 reverse;
    logic                 mem_read;
    logic                 mem_write;
    logic                 write_back;
    decode_pkg::shamt_t   shamt;
    decode_pkg::shdir_t   shdir;
    decode_pkg::imm_t     imm;
    decode_pkg::reg_idx_t rd;
    decode_pkg::reg_idx_t rm;
    decode_pkg::reg_idx_t rn;
    decode_pkg::int_vec_t int_line;

    ctrl_t observed;
    ctrl_t exp_q[$];                            // Accepted, not yet taken by execute
    int    mismatch_cnt = 0;
    int    fail_cnt     = 0;
    int    cycles       = 0;

    `include "decode_vectors.svh"

    decode_stage DUT (.*);

    always #4 clk = ~clk;

    // Execute stalls about one cycle in three
    always @(posedge clk) begin
        exec_rdy <= ($urandom % 3) != 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= vecs.size() * 40) begin
            $display("Timeout after %0d cycles, the stage stopped responding", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    assign observed = {alu_op, src_imm, reverse, mem_read, mem_write, write_back,
                       shamt, shdir, imm, rd, rm, rn};

    // Held fields must match the oldest accepted word on every cycle
    always @(posedge clk) begin
        if (!reset && exec_req) begin
            assert (exp_q.size() != 0) else begin
                fail_cnt++;
                $display("Execute request at %0t ns with no instruction outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                assert (observed == exp_q[0]) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t ns: decoded fields %h, expected %h",
                             $time, observed, exp_q[0]);
                end
                if (exec_rdy) begin
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    function automatic ctrl_t expect_ctrl(input vec_t v, input decode_pkg::inst_t w);
        decode_pkg::imm_t   e_imm;
        decode_pkg::shamt_t e_shamt;
        e_imm   = v.flags[4] ? w[15:0] : 16'd0;     // Immediate forms carry imm
        e_shamt = v.flags[4] ? 5'd0 : w[11:7];
        return {v.alu_op, v.flags, e_shamt, w[6:5], e_imm, w[23:20], w[19:16], w[15:12]};
    endfunction

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!exec_req && int_line == '0 && inst_rdy) else begin
            fail_cnt++;
            $display("Stage not idle after reset at %0t ns", $time);
        end
    endtask

    // Wait for the edge where fetch hands over the word
    task automatic offer_word();
        do begin
            @(posedge clk);
            assert (int_line == '0) else begin
                fail_cnt++;
                $display("Interrupt raised at %0t ns without a trap", $time);
            end
        end while (!inst_rdy);
    endtask

    // Pulse is due one edge after the first edge with an empty stage and exec_rdy
    task automatic check_trap(input vec_t v);
        decode_pkg::int_vec_t exp_vec;
        logic                 drained;
        logic                 pulse_due;
        exp_vec = 24'd1 << v.line;
        drained = 1'b0;
        do begin
            @(posedge clk);
            assert (!inst_rdy) else begin
                fail_cnt++;
                $display("Fetch ready at %0t ns while the stage is halted", $time);
            end
            assert (v.line >= 0 || int_line == '0) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t ns: int_line %h, expected none", $time, int_line);
            end
            pulse_due = drained;
            drained   = exec_rdy && !exec_req;
        end while (!pulse_due);
        assert (v.line < 0 || int_line == exp_vec) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: int_line %h, expected %h", $time, int_line, exp_vec);
        end
        assert (exp_q.size() == 0) else begin
            fail_cnt++;
            $display("Trap finished at %0t ns with instructions still queued", $time);
        end
        repeat (6) begin
            @(posedge clk);
            assert (int_line == '0 && !inst_rdy && !exec_req) else begin
                fail_cnt++;
                $display("Stage left the halted state at %0t ns", $time);
            end
        end
    endtask

    initial begin
        vec_t              v;
        decode_pkg::inst_t word;
        logic [31:0]       rnd;
        void'($urandom(61));
        reset    = 1'b1;
        inst     = '0;
        inst_req = 1'b0;
        fill_table();
        apply_reset();
        for (int i = 0; i < vecs.size(); i++) begin
            v   = vecs[i];
            rnd = $urandom;
            if (v.opcode == decode_pkg::OP_INT) begin
                word = {v.opcode, rnd[23:16], v.int_num};
            end else begin
                word = {v.opcode, rnd[23:0]};
            end
            inst     <= word;
            inst_req <= 1'b1;
            offer_word();
            if (v.trap) begin
                inst_req <= 1'b0;
                check_trap(v);
                apply_reset();
            end else begin
                exp_q.push_back(expect_ctrl(v, word));
            end
        end
        inst_req <= 1'b0;
        do @(posedge clk); while (exec_req);
        assert (exp_q.size() == 0) else begin
            fail_cnt++;
            $display("%0d accepted instructions never reached execute", exp_q.size());
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+tb
design/decode_pkg.sv
design/decode_flow.sv
design/inst_decoder.sv
design/trap_ctrl.sv
design/decode_stage.sv
tb/decode_tb.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module decode_tb -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdecode_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
